//--- compile.f
logic/fetch_pkg.sv
logic/fetch_addr_fifo.sv
logic/fetch_match_queue.sv
logic/branch_predictor.sv
logic/fetch_stage.sv
logic/fetch_unit.sv
tests/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/bash
# Builds the fetch unit testbench with Verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 -f compile.f --top-module fetch_unit_tb \
	-o fetch_unit_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fetch_unit_sim > sim.log 2>&1
cat sim.log
grep -q 'All tests passed!' sim.log && echo "Simulation PASSED" || {
	echo "Simulation FAILED"
	exit 1
}

//--- tests/fetch_unit_tb.sv
/*
 * Testbench for the fetch unit: models an in-order instruction memory and decode,
 * applies the scenario table in a loop and checks every packet handed to decode.
 */
`timescale 1ns/10ps

module fetch_unit_tb;

	import fetch_pkg::*;

	localparam logic [31:0] BR_ADDR   = 32'h18; // Only branch in the program
	localparam logic [31:0] BR_TARGET = 32'h40;
	localparam logic [31:0] NOP_WORD  = 32'h0000_0000;
	localparam int          N_SCEN    = 7;
	localparam int          PKT_WAIT  = 400; // Cycles allowed per scenario

	typedef struct packed {
		logic [1:0]  train;      // 0 none, 1 taken update, 2 not-taken update
		logic        jump;
		logic [31:0] jump_pc;
		logic [31:0] first_pc;   // next_pc of the first packet
		logic [15:0] lock_mask;
		logic [15:0] stop_mask;
		logic [15:0] flock_mask;
		logic [15:0] hold_mask;
		logic [7:0]  n_pkts;
	} scen_t;

	logic       iCLOCK;
	logic       inRESET;
	logic       reset_sync;
	psr_t       psr;
	logic       event_hold;
	logic       event_start;
	logic       event_end;
	logic       setreg_pc_set;
	addr_t      setreg_pc;
	logic       fetch_req;
	logic       fetch_lock;
	addr_t      fetch_addr;
	logic       inst_valid;
	inst_t      inst;
	mmu_flags_t mmu_flags;
	logic       next_inst_valid;
	inst_t      next_inst;
	addr_t      next_pc;
	mmu_flags_t next_mmu_flags;
	logic       next_paging_ena;
	logic       next_kernel_access;
	logic       next_predict;
	addr_t      next_predict_addr;
	logic       next_lock;
	logic       fetch_stop;
	logic       prev_lock;
	logic       predict_flush;
	logic       pred_update_stb;
	logic       pred_update_taken;
	addr_t      pred_update_inst_addr;
	addr_t      pred_update_target;

	scen_t        scen_tbl [N_SCEN];
	inst_t        prog [32];
	logic [31:0]  mq_addr [$];   // Outstanding requests in memory
	int           mq_ready [$];
	logic [111:0] out_bundle;
	logic [111:0] out_snap;
	addr_t        addr_snap;
	addr_t        exp_addr;
	addr_t        first_pc_exp;
	addr_t        jump_pc_cmd;
	logic lock_cmd, stop_cmd, flock_cmd, hold_cmd;
	logic start_cmd, jump_cmd, upd_cmd, upd_taken;
	logic lock_seen, hold_seen, checking, expect_idle, mem_busy, bp_valid_m;
	int   bp_cnt_m, pkt_count, checks, errors, timeouts, cyc, last_ready;

	assign out_bundle = {next_inst_valid, next_inst, next_pc, next_mmu_flags, next_paging_ena,
		next_kernel_access, next_predict, next_predict_addr};

	fetch_unit #(.FIFO_DEPTH(8), .MATCH_DEPTH(16), .BTB_ENTRIES(8)) DUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	function automatic inst_t prog_word(input addr_t a);
		if (a < 32'h80 && a[1:0] == 2'b00) begin
			return prog[a[6:2]];
		end
		return NOP_WORD; // Outside the program
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR @%0t: %s", $time, msg);
	endtask

	// Runs on every edge before any input changes
	task automatic check_outputs();
		logic exp_pred;
		logic exp_flush;
		exp_pred = (exp_addr == BR_ADDR) && bp_valid_m && (bp_cnt_m >= 2);
		exp_flush = 1'b0;
		if (inst_valid === 1'b1 && mq_addr.size() > 0) begin // Word on the bus
			exp_flush = (mq_addr[0] == BR_ADDR) && bp_valid_m && (bp_cnt_m >= 2)
				&& !next_lock && !event_hold;
		end
		if (lock_seen && out_bundle !== out_snap) report_error("outputs changed under next_lock");
		if (hold_seen && fetch_addr !== addr_snap) report_error("fetch_addr moved under event_hold");
		if ((fetch_stop || fetch_lock || event_hold) && fetch_req !== 1'b0) begin
			report_error($sformatf("fetch_req high while blocked, addr %h", fetch_addr));
		end
		if (prev_lock !== next_lock) report_error("prev_lock does not follow next_lock");
		if (predict_flush !== exp_flush) begin
			report_error($sformatf("predict_flush %b, expected %b", predict_flush, exp_flush));
		end
		if (expect_idle && (next_inst_valid !== 1'b0 || fetch_req !== 1'b0)) begin
			report_error("packet or request right after event_start");
		end
		expect_idle = 1'b0;
		if (checking && next_inst_valid === 1'b1 && !next_lock) begin
			checks++;
			if (pkt_count == 0 && next_pc !== first_pc_exp) begin
				report_error($sformatf("first next_pc %h, expected %h", next_pc, first_pc_exp));
			end
			if (next_pc !== exp_addr + 32'd4 || next_inst !== prog_word(exp_addr)) begin
				report_error($sformatf("packet pc %h inst %h, expected pc %h inst %h", next_pc,
					next_inst, exp_addr + 32'd4, prog_word(exp_addr)));
			end
			if (next_mmu_flags !== exp_addr[13:2] || next_paging_ena !== (psr[1:0] != 2'b00)
				|| next_kernel_access !== (psr[6:5] == 2'b00)) begin
				report_error($sformatf("flags wrong on packet at %h", exp_addr));
			end
			if (next_predict !== exp_pred || (exp_pred && next_predict_addr !== BR_TARGET)) begin
				report_error($sformatf("predict %b to %h at %h, expected %b", next_predict,
					next_predict_addr, exp_addr, exp_pred));
			end
			exp_addr = exp_pred ? BR_TARGET : exp_addr + 32'd4;
			pkt_count++;
		end
		lock_seen = next_lock;
		hold_seen = event_hold;
		out_snap  = out_bundle;
		addr_snap = fetch_addr;
	endtask

	// One clock edge: check, advance the memory model, drive inputs
	task automatic step();
		int lat;
		int rdy;
		@(posedge iCLOCK);
		check_outputs();
		if (mem_busy) begin
			void'(mq_addr.pop_front());
			void'(mq_ready.pop_front());
		end
		if (fetch_req) begin
			lat = 1 + int'($urandom % 3);
			rdy = (cyc + lat > last_ready) ? cyc + lat : last_ready + 1; // In order
			mq_addr.push_back(fetch_addr);
			mq_ready.push_back(rdy);
			last_ready = rdy;
		end
		cyc++;
		if (event_start) begin // Memory drops its queue on an exception
			mq_addr.delete();
			mq_ready.delete();
			last_ready = cyc;
		end
		mem_busy = 1'b0;
		if (mq_addr.size() > 0 && !lock_cmd) begin
			mem_busy = (mq_ready[0] <= cyc);
		end
		inst_valid <= mem_busy;
		if (mem_busy) begin
			inst      <= prog_word(mq_addr[0]);
			mmu_flags <= mq_addr[0][13:2];
		end
		next_lock         <= lock_cmd;
		fetch_stop        <= stop_cmd;
		fetch_lock        <= flock_cmd;
		event_hold        <= hold_cmd;
		event_start       <= start_cmd;
		event_end         <= jump_cmd;
		setreg_pc_set     <= jump_cmd;
		setreg_pc         <= jump_pc_cmd;
		pred_update_stb   <= upd_cmd;
		pred_update_taken <= upd_taken;
	endtask

	task automatic run_scenario(input scen_t sc, input int idx);
		int guard;
		checking = 1'b0;
		if (sc.train != 2'd0) begin
			upd_cmd   = 1'b1;
			upd_taken = (sc.train == 2'd1);
			step();
			upd_cmd = 1'b0;
			if (upd_taken && !bp_valid_m) begin // Allocation
				bp_valid_m = 1'b1;
				bp_cnt_m   = 2;
			end else if (upd_taken && bp_cnt_m < 3) begin
				bp_cnt_m++;
			end else if (!upd_taken && bp_valid_m && bp_cnt_m > 0) begin
				bp_cnt_m--;
			end
		end
		if (idx != 0) begin
			start_cmd = 1'b1;
			step();
			start_cmd   = 1'b0;
			jump_cmd    = sc.jump;
			jump_pc_cmd = sc.jump_pc;
			step();
			jump_cmd    = 1'b0;
			expect_idle = 1'b1;
			step();
		end
		exp_addr     = sc.jump ? {sc.jump_pc[31:1], 1'b0} : 32'h0;
		first_pc_exp = sc.first_pc;
		pkt_count    = 0;
		checking     = 1'b1;
		guard        = 0;
		while (pkt_count < int'(sc.n_pkts) && guard < PKT_WAIT) begin
			lock_cmd  = sc.lock_mask[guard % 16];
			stop_cmd  = sc.stop_mask[guard % 16];
			flock_cmd = sc.flock_mask[guard % 16];
			hold_cmd  = sc.hold_mask[guard % 16];
			step();
			guard++;
		end
		{lock_cmd, stop_cmd, flock_cmd, hold_cmd} = 4'b0000;
		if (pkt_count < int'(sc.n_pkts)) begin
			timeouts++;
			$display("Timed out in scenario %0d: %0d of %0d packets arrived", idx, pkt_count,
				sc.n_pkts);
		end
	endtask

	initial begin
		void'($urandom(27));
		{inRESET, reset_sync, event_hold, event_start, event_end, setreg_pc_set} = '0;
		{fetch_lock, inst_valid, next_lock, fetch_stop, pred_update_stb, pred_update_taken} = '0;
		psr = 32'h0000_0021; // Paging on, user mode
		setreg_pc = '0;
		inst = '0;
		mmu_flags = '0;
		pred_update_inst_addr = BR_ADDR;
		pred_update_target = BR_TARGET;
		{lock_cmd, stop_cmd, flock_cmd, hold_cmd, start_cmd, jump_cmd, upd_cmd, upd_taken} = '0;
		{lock_seen, hold_seen, checking, expect_idle, mem_busy, bp_valid_m} = '0;
		{bp_cnt_m, pkt_count, checks, errors, timeouts, cyc, last_ready} = '0;
		jump_pc_cmd = '0;
		for (int i = 0; i < 32; i++) begin
			prog[i] = 32'h1000_0000 + 32'(i);
		end
		prog[6] = {1'b0, OC_B, 21'd6}; // Branch at BR_ADDR
		scen_tbl[0] = '{2'd0, 1'b0, 32'h0, 32'h4, 16'h0, 16'h0, 16'h0, 16'h0, 8'd24};
		scen_tbl[1] = '{2'd0, 1'b0, 32'h0, 32'h4, 16'h0F0F, 16'h0, 16'h0, 16'h0, 8'd24};
		scen_tbl[2] = '{2'd0, 1'b0, 32'h0, 32'h4, 16'h0, 16'h00F0, 16'h0F00, 16'h0, 8'd24};
		scen_tbl[3] = '{2'd0, 1'b0, 32'h0, 32'h4, 16'h0, 16'h0, 16'h0, 16'h0FF0, 8'd24};
		scen_tbl[4] = '{2'd0, 1'b1, 32'h25, 32'h28, 16'h0, 16'h0, 16'h0, 16'h0, 8'd12};
		scen_tbl[5] = '{2'd1, 1'b0, 32'h0, 32'h4, 16'h0, 16'h0, 16'h0, 16'h0, 8'd20};
		scen_tbl[6] = '{2'd2, 1'b0, 32'h0, 32'h4, 16'h0, 16'h0, 16'h0, 16'h0, 8'd24};
		repeat (8) step(); // Reset held 8 cycles
		inRESET <= 1'b1;
		for (int s = 0; s < N_SCEN; s++) begin
			run_scenario(scen_tbl[s], s);
		end
		$display("Packets checked: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- logic/fetch_unit.sv
/*
 * Fetch front end top: fetch stage with its address FIFO, match queue and BTB.
 * Connects to instruction memory on one side and decode on the other.
 */
`timescale 1ns/10ps

module fetch_unit #(
	parameter int FIFO_DEPTH  = 8,
	parameter int MATCH_DEPTH = 16,
	parameter int BTB_ENTRIES = 8
) (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  reset_sync,
	input  fetch_pkg::psr_t       psr,
	input  logic                  event_hold,
	input  logic                  event_start,
	input  logic                  event_end,
	input  logic                  setreg_pc_set,
	input  fetch_pkg::addr_t      setreg_pc,
	// Instruction memory
	output logic                  fetch_req,
	input  logic                  fetch_lock,
	output fetch_pkg::addr_t      fetch_addr,
	input  logic                  inst_valid,
	input  fetch_pkg::inst_t      inst,
	input  fetch_pkg::mmu_flags_t mmu_flags,
	// Decode
	output logic                  next_inst_valid,
	output fetch_pkg::inst_t      next_inst,
	output fetch_pkg::addr_t      next_pc,
	output fetch_pkg::mmu_flags_t next_mmu_flags,
	output logic                  next_paging_ena,
	output logic                  next_kernel_access,
	output logic                  next_predict,
	output fetch_pkg::addr_t      next_predict_addr,
	input  logic                  next_lock,
	input  logic                  fetch_stop,
	output logic                  prev_lock,
	output logic                  predict_flush,
	// Branch resolution
	input  logic                  pred_update_stb,
	input  logic                  pred_update_taken,
	input  fetch_pkg::addr_t      pred_update_inst_addr,
	input  fetch_pkg::addr_t      pred_update_target
);

	import fetch_pkg::*;

	logic                    q_clear;
	logic                    q_wr;
	logic [FIFO_ENTRY_W-1:0] q_wr_data;
	logic                    q_full;
	logic                    q_rd;
	logic [FIFO_ENTRY_W-1:0] q_rd_data;
	logic                    m_full;
	logic                    m_valid;
	logic                    bp_search_stb;
	addr_t                   bp_search_addr;
	logic                    bp_valid;
	logic                    bp_taken;
	addr_t                   bp_target;

	fetch_stage #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.MATCH_DEPTH(MATCH_DEPTH)
	) u_stage (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .reset_sync(reset_sync), .psr(psr),
		.event_hold(event_hold), .event_start(event_start), .event_end(event_end),
		.setreg_pc_set(setreg_pc_set), .setreg_pc(setreg_pc),
		.fetch_req(fetch_req), .fetch_lock(fetch_lock), .fetch_addr(fetch_addr),
		.inst_valid(inst_valid), .inst(inst), .mmu_flags(mmu_flags),
		.next_inst_valid(next_inst_valid), .next_inst(next_inst), .next_pc(next_pc),
		.next_mmu_flags(next_mmu_flags), .next_paging_ena(next_paging_ena),
		.next_kernel_access(next_kernel_access), .next_predict(next_predict),
		.next_predict_addr(next_predict_addr), .next_lock(next_lock),
		.fetch_stop(fetch_stop), .prev_lock(prev_lock),
		.q_clear(q_clear), .q_wr(q_wr), .q_wr_data(q_wr_data), .q_full(q_full),
		.q_rd(q_rd), .q_rd_data(q_rd_data), .m_full(m_full), .m_valid(m_valid),
		.bp_search_stb(bp_search_stb), .bp_search_addr(bp_search_addr),
		.bp_valid(bp_valid), .bp_taken(bp_taken), .bp_target(bp_target),
		.predict_flush(predict_flush)
	);

	fetch_addr_fifo #(
		.DEPTH(FIFO_DEPTH),
		.WIDTH(FIFO_ENTRY_W)
	) u_addr_fifo (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clear(q_clear),
		.wr_en(q_wr), .wr_data(q_wr_data), .full(q_full),
		.rd_en(q_rd), .rd_data(q_rd_data), .empty()
	);

	fetch_match_queue #(
		.DEPTH(MATCH_DEPTH)
	) u_match_queue (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clear(q_clear),
		.wr_req(q_wr), .rd_req(q_rd), .full(m_full), .rd_valid(m_valid)
	);

	// BTB contents survive redirects; only a synchronous reset wipes them
	branch_predictor #(
		.ENTRIES(BTB_ENTRIES)
	) u_btb (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clear(reset_sync),
		.search_stb(bp_search_stb), .search_addr(bp_search_addr),
		.search_valid(bp_valid), .search_taken(bp_taken), .search_target(bp_target),
		.pred_update_stb(pred_update_stb), .pred_update_taken(pred_update_taken),
		.pred_update_inst_addr(pred_update_inst_addr),
		.pred_update_target(pred_update_target)
	);

endmodule

//--- logic/fetch_stage.sv
/*
 * Fetch FSM, fetch PC and request gating toward instruction memory.
 * Pairs each returned word with its queued address and registers it for decode.
 */
`timescale 1ns/10ps

module fetch_stage #(
	parameter int FIFO_DEPTH  = 8,
	parameter int MATCH_DEPTH = 16
) (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 reset_sync,
	input  fetch_pkg::psr_t      psr,
	input  logic                 event_hold,
	input  logic                 event_start,
	input  logic                 event_end,
	input  logic                 setreg_pc_set,
	input  fetch_pkg::addr_t     setreg_pc,
	// Instruction memory
	output logic                 fetch_req,
	input  logic                 fetch_lock,
	output fetch_pkg::addr_t     fetch_addr,
	input  logic                 inst_valid,
	input  fetch_pkg::inst_t     inst,
	input  fetch_pkg::mmu_flags_t mmu_flags,
	// Decode
	output logic                 next_inst_valid,
	output fetch_pkg::inst_t     next_inst,
	output fetch_pkg::addr_t     next_pc,
	output fetch_pkg::mmu_flags_t next_mmu_flags,
	output logic                 next_paging_ena,
	output logic                 next_kernel_access,
	output logic                 next_predict,
	output fetch_pkg::addr_t     next_predict_addr,
	input  logic                 next_lock,
	input  logic                 fetch_stop,
	output logic                 prev_lock,
	// Address FIFO and match queue
	output logic                 q_clear,
	output logic                 q_wr,
	output logic [fetch_pkg::FIFO_ENTRY_W-1:0] q_wr_data,
	input  logic                 q_full,
	output logic                 q_rd,
	input  logic [fetch_pkg::FIFO_ENTRY_W-1:0] q_rd_data,
	input  logic                 m_full,
	input  logic                 m_valid,
	// Branch target buffer
	output logic                 bp_search_stb,
	output fetch_pkg::addr_t     bp_search_addr,
	input  logic                 bp_valid,
	input  logic                 bp_taken,
	input  fetch_pkg::addr_t     bp_target,
	output logic                 predict_flush
);

	import fetch_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;
	addr_t        fetch_pc;
	logic         jump;
	logic         bp_hit;
	logic         ret_match;
	addr_t        head_addr;
	logic         head_paging;
	logic         head_kernel;

	function automatic logic is_branch(input inst_t word);
		case (word[30:21])
			OC_B, OC_BR, OC_BUR: return 1'b1;
			default:             return 1'b0;
		endcase
	endfunction

	// Queue entries pair one to one; extra FIFO depth would never fill
	initial begin
		assert (FIFO_DEPTH >= 2 && MATCH_DEPTH >= FIFO_DEPTH)
			else $error("fetch_stage: bad queue depths");
	end

	assign jump      = event_end && setreg_pc_set;
	assign ret_match = inst_valid && m_valid; // Word of the current stream
	assign {head_kernel, head_paging, head_addr} = q_rd_data;

	always_comb begin
		state_next = state;
		if (reset_sync) begin
			state_next = FETCH_IDLE;
		end else if (jump) begin
			state_next = FETCH_READ;
		end else if (event_start || event_hold || predict_flush) begin
			state_next = FETCH_IDLE;
		end else if (state == FETCH_IDLE) begin
			state_next = FETCH_READ;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= FETCH_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign fetch_req = (state == FETCH_READ) && !reset_sync && !jump && !event_start
		&& !event_hold && !predict_flush && !q_full && !m_full && !fetch_lock && !fetch_stop;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			fetch_pc <= '0;
		end else if (reset_sync) begin
			fetch_pc <= '0;
		end else if (jump) begin
			fetch_pc <= {setreg_pc[31:1], 1'b0};
		end else if (event_start) begin
			fetch_pc <= '0;
		end else if (event_hold) begin
			fetch_pc <= fetch_pc;
		end else if (predict_flush) begin
			fetch_pc <= bp_target; // Early redirect
		end else if (fetch_req) begin
			fetch_pc <= fetch_pc + 32'd4;
		end
	end

	assign fetch_addr = fetch_pc;
	assign prev_lock  = next_lock;

	// Queue control
	assign q_wr      = fetch_req;
	assign q_wr_data = {psr[6:5] == 2'b00, psr[1:0] != 2'b00, fetch_pc};
	assign q_rd      = ret_match && !next_lock;
	assign q_clear   = reset_sync || event_start || predict_flush;

	// Branch prediction on returned words
	assign bp_search_stb  = ret_match && is_branch(inst);
	assign bp_search_addr = head_addr;
	assign bp_hit         = bp_valid && bp_taken;
	assign predict_flush  = bp_hit && !next_lock && !event_hold;

	// The predicted branch itself still goes to decode
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			next_inst_valid <= 1'b0;
			next_predict    <= 1'b0;
		end else if (reset_sync || event_start) begin
			next_inst_valid <= 1'b0;
			next_predict    <= 1'b0;
		end else if (!next_lock) begin
			next_inst_valid <= ret_match;
			next_predict    <= bp_hit;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!next_lock) begin
			next_inst          <= inst;
			next_pc            <= head_addr + 32'd4;
			next_mmu_flags     <= mmu_flags;
			next_paging_ena    <= head_paging;
			next_kernel_access <= head_kernel;
			next_predict_addr  <= bp_target;
		end
	end

	a_req_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(fetch_req && fetch_lock));

endmodule

//--- logic/branch_predictor.sv
/*
 * Direct-mapped branch target buffer with 2-bit saturating counters.
 * Search answers in the same cycle; updates land on the next edge.
 */
`timescale 1ns/10ps

module branch_predictor #(
	parameter int ENTRIES = 8 // Power of two, at least 2
) (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             clear,
	// Search
	input  logic             search_stb,
	input  fetch_pkg::addr_t search_addr,
	output logic             search_valid,
	output logic             search_taken,
	output fetch_pkg::addr_t search_target,
	// Update from branch resolution
	input  logic             pred_update_stb,
	input  logic             pred_update_taken,
	input  fetch_pkg::addr_t pred_update_inst_addr,
	input  fetch_pkg::addr_t pred_update_target
);

	import fetch_pkg::*;

	localparam int IDX_W = $clog2(ENTRIES);
	localparam int TAG_W = 32 - 2 - IDX_W;

	logic [ENTRIES-1:0] valid_q;
	logic [TAG_W-1:0]   tag_q    [ENTRIES];
	addr_t              target_q [ENTRIES];
	bp_counter_t        count_q  [ENTRIES];

	logic [IDX_W-1:0] s_idx;
	logic [TAG_W-1:0] s_tag;
	logic [IDX_W-1:0] u_idx;
	logic [TAG_W-1:0] u_tag;
	logic             u_hit;

	// Word aligned, so the index starts at bit 2
	assign s_idx = search_addr[IDX_W+1:2];
	assign s_tag = search_addr[31:IDX_W+2];
	assign u_idx = pred_update_inst_addr[IDX_W+1:2];
	assign u_tag = pred_update_inst_addr[31:IDX_W+2];

	assign u_hit = valid_q[u_idx] && (tag_q[u_idx] == u_tag);

	assign search_valid  = search_stb && valid_q[s_idx] && (tag_q[s_idx] == s_tag);
	assign search_taken  = search_valid && (count_q[s_idx] >= bp_counter_t'(2));
	assign search_target = target_q[s_idx];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
		end else if (clear) begin
			valid_q <= '0;
		end else if (pred_update_stb && pred_update_taken) begin
			valid_q[u_idx] <= 1'b1; // Allocate on a taken branch
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (pred_update_stb) begin
			if (pred_update_taken) begin
				tag_q[u_idx]    <= u_tag;
				target_q[u_idx] <= pred_update_target;
				if (!u_hit) begin
					count_q[u_idx] <= bp_counter_t'(2); // Fresh entry, weakly taken
				end else if (count_q[u_idx] != '1) begin
					count_q[u_idx] <= count_q[u_idx] + 1'b1;
				end
			end else if (u_hit && count_q[u_idx] != '0) begin
				count_q[u_idx] <= count_q[u_idx] - 1'b1;
			end
		end
	end

endmodule

//--- logic/fetch_match_queue.sv
/*
 * Counts fetch requests still waiting for their word.
 * A return with nothing outstanding is stale and its read is ignored.
 */
`timescale 1ns/10ps

module fetch_match_queue #(
	parameter int DEPTH = 16
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic clear,
	input  logic wr_req,
	input  logic rd_req,
	output logic full,
	output logic rd_valid
);

	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_req && !full;
	assign do_rd = rd_req && rd_valid; // Filters returns after a flush

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (do_wr && !do_rd) begin
			count <= count + 1'b1;
		end else if (do_rd && !do_wr) begin
			count <= count - 1'b1;
		end
	end

	assign full     = (count == CNT_W'(DEPTH));
	assign rd_valid = (count != '0);

	a_count_bound: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		count <= CNT_W'(DEPTH));

endmodule

//--- logic/fetch_addr_fifo.sv
/*
 * Show-ahead FIFO for outstanding fetch requests.
 * rd_data always presents the head entry; rd_en pops it.
 */
`timescale 1ns/10ps

module fetch_addr_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 34
) (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             clear,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	output logic             full,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// Wraps at DEPTH, so DEPTH need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge iCLOCK) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin // Drop everything in one cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign rd_data = mem[rd_ptr]; // Head entry, no read latency

	a_no_overflow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		wr_en |-> !full);
	a_no_underflow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_en |-> !empty);

endmodule

//--- logic/fetch_pkg.sv
/*
 * Shared types and constants of the instruction fetch front end.
 * Modules import it inside their body and use scoped names in their ports.
 */
package fetch_pkg;

	typedef logic [31:0] addr_t;       // Instruction byte address
	typedef logic [31:0] inst_t;       // Instruction word
	typedef logic [11:0] mmu_flags_t;  // Fault and attribute flags from memory
	typedef logic [31:0] psr_t;        // Processor status register
	typedef logic [1:0]  bp_counter_t; // 2 or more predicts taken

	typedef enum logic {
		FETCH_IDLE,
		FETCH_READ
	} fetch_state_t;

	// Branch opcodes, instruction bits 30:21
	localparam logic [9:0] OC_B   = 10'h130;
	localparam logic [9:0] OC_BR  = 10'h131;
	localparam logic [9:0] OC_BUR = 10'h132;

	// Address queue entry: {kernel, paging, address}
	localparam int FIFO_ENTRY_W = 34;

endpackage
